// ==== compile.f ====
stlb_pkg.sv
stlb_tag_ecc_ram.sv
stlb_ram_arbiter.sv
stlb_refill.sv
stlb_lookup.sv
stlb_top.sv
tb_stlb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_stlb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_stlb.sv ====
// Runs stlb_top at INDEX_W = 3; lookups start only after every entry has been invalidated.
`timescale 1ns/1ps

module tb_stlb import stlb_pkg::*; ();

	localparam int INDEX_W    = 3;
	localparam int ENTRIES    = 2 ** INDEX_W;
	localparam int CLK_PERIOD = 100;
	localparam int N_RAND     = 200;
	localparam int TOTAL_OPS  = 24 + 24 + 8 + 16 + 2 * N_RAND + 16;

	logic             clk;
	logic             rst_n;
	logic             refill_valid;
	stlb_refill_op_e  refill_op;
	logic [VPN_W-1:0] refill_vpn;
	logic [PPN_W-1:0] refill_ppn;
	stlb_inject_e     refill_inject;
	logic             lookup_req;
	logic [VPN_W-1:0] lookup_vpn;
	logic             lookup_busy;
	logic             resp_valid;
	logic             resp_hit;
	logic [PPN_W-1:0] resp_ppn;
	stlb_ecc_e        resp_ecc;

	integer seed;
	int     n_pass;
	int     n_errors;
	int     n_req;
	int     n_resp;
	int     test_errors;

	// Reference copy of the tag array, one record per index.
	logic             ent_valid [ENTRIES];
	logic [VPN_W-1:0] ent_vpn [ENTRIES];
	logic [PPN_W-1:0] ent_ppn [ENTRIES];
	stlb_inject_e     ent_inject [ENTRIES];

	// Mirror of stage A: a request that has not yet been granted.
	logic             pend;
	logic [VPN_W-1:0] pend_vpn;
	logic             exp_hit_q [$];
	logic [PPN_W-1:0] exp_ppn_q [$];
	stlb_ecc_e        exp_ecc_q [$];

	stlb_top #(
		.INDEX_W (INDEX_W)
	) UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.refill_valid  (refill_valid),
		.refill_op     (refill_op),
		.refill_vpn    (refill_vpn),
		.refill_ppn    (refill_ppn),
		.refill_inject (refill_inject),
		.lookup_req    (lookup_req),
		.lookup_vpn    (lookup_vpn),
		.lookup_busy   (lookup_busy),
		.resp_valid    (resp_valid),
		.resp_hit      (resp_hit),
		.resp_ppn      (resp_ppn),
		.resp_ecc      (resp_ecc)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ############################################################
	// Random values and expected results
	// ############################################################

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic logic [VPN_W-1:0] rand_vpn();
		logic [31:0] r;
		r = $random(seed);
		return r[VPN_W-1:0];
	endfunction

	function automatic logic [PPN_W-1:0] rand_ppn();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[PPN_W-1:0];
	endfunction

	// One flipped bit is repaired, two flipped bits are only detected.
	function automatic stlb_ecc_e ecc_for(input stlb_inject_e inj);
		case (inj)
			INJECT_SINGLE: return ECC_CORRECTED;
			INJECT_DOUBLE: return ECC_UNCORR;
			default: return ECC_CLEAN;
		endcase
	endfunction

	task automatic predict(input logic [VPN_W-1:0] vpn);
		int        idx;
		stlb_ecc_e ecc;
		idx = int'(vpn[INDEX_W-1:0]);
		ecc = ecc_for(ent_inject[idx]);
		exp_hit_q.push_back(ent_valid[idx] && (ent_vpn[idx] == vpn) && (ecc != ECC_UNCORR));
		exp_ppn_q.push_back(ent_ppn[idx]);
		exp_ecc_q.push_back(ecc);
	endtask

	task automatic compare_hit(input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: resp_hit expected %h got %h", exp, act);
			n_errors++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic compare_ppn(input logic [PPN_W-1:0] exp, input logic [PPN_W-1:0] act);
		if (act !== exp) begin
			$display("** Error: resp_ppn expected %h got %h", exp, act);
			n_errors++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic compare_ecc(input stlb_ecc_e exp, input stlb_ecc_e act);
		if (act !== exp) begin
			$display("** Error: resp_ecc expected %h got %h", exp, act);
			n_errors++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_response();
		logic             exp_hit;
		logic [PPN_W-1:0] exp_ppn;
		stlb_ecc_e        exp_ecc;
		n_resp++;
		if (exp_hit_q.size() == 0) begin
			$display("Response arrived while no lookup was outstanding");
			n_errors++;
		end else begin
			exp_hit = exp_hit_q.pop_front();
			exp_ppn = exp_ppn_q.pop_front();
			exp_ecc = exp_ecc_q.pop_front();
			compare_hit(exp_hit, resp_hit);
			compare_ecc(exp_ecc, resp_ecc);
			if (exp_hit) begin
				compare_ppn(exp_ppn, resp_ppn);
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst_n && resp_valid) begin
			check_response();
		end
	end

	// ############################################################
	// Stimulus, one call per clock cycle
	// ############################################################

	task automatic drive_cycle(
		input logic             do_ref,
		input stlb_refill_op_e  op,
		input logic [VPN_W-1:0] rvpn,
		input logic [PPN_W-1:0] rppn,
		input stlb_inject_e     inj,
		input logic             do_lk,
		input logic [VPN_W-1:0] lvpn
	);
		logic busy_exp;
		int   idx;
		@(posedge clk);
		// Stage A is busy in this cycle when a request was still ungranted at its start.
		busy_exp = pend;
		refill_valid  <= do_ref;
		refill_op     <= op;
		refill_vpn    <= rvpn;
		refill_ppn    <= rppn;
		refill_inject <= inj;
		lookup_req    <= do_lk;
		lookup_vpn    <= lvpn;
		if (do_ref) begin
			idx = int'(rvpn[INDEX_W-1:0]);
			ent_valid[idx]  = (op == REFILL_WRITE);
			ent_vpn[idx]    = (op == REFILL_WRITE) ? rvpn : '0;
			ent_ppn[idx]    = (op == REFILL_WRITE) ? rppn : '0;
			ent_inject[idx] = inj;
		end
		if (do_lk) begin
			pend     = 1'b1;
			pend_vpn = lvpn;
			n_req++;
		end
		// The read is granted in any cycle that carries no refill write.
		if (pend && !do_ref) begin
			predict(pend_vpn);
			pend = 1'b0;
		end
		@(negedge clk);
		if (lookup_busy !== busy_exp) begin
			$display("** Error: lookup_busy expected %h got %h", busy_exp, lookup_busy);
			n_errors++;
		end
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, REFILL_WRITE, '0, '0, INJECT_NONE, 1'b0, '0);
	endtask

	task automatic issue_refill(input stlb_refill_op_e op, input logic [VPN_W-1:0] vpn,
			input logic [PPN_W-1:0] ppn, input stlb_inject_e inj);
		drive_cycle(1'b1, op, vpn, ppn, inj, 1'b0, '0);
	endtask

	task automatic issue_lookup(input logic [VPN_W-1:0] vpn);
		while (pend) begin
			idle_cycle();
		end
		drive_cycle(1'b0, REFILL_WRITE, '0, '0, INJECT_NONE, 1'b1, vpn);
	endtask

	task automatic close_test(input string name);
		idle_cycle();
		while (pend) begin
			idle_cycle();
		end
		while (exp_hit_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		$display("test %s: %0d errors", name, n_errors - test_errors);
		test_errors = n_errors;
	endtask

	// ############################################################
	// Tests
	// ############################################################

	task automatic check_invalidated_miss();
		logic [VPN_W-1:0] v;
		for (int i = 0; i < ENTRIES; i++) begin
			v = '0;
			v[INDEX_W-1:0] = i[INDEX_W-1:0];
			issue_refill(REFILL_INVAL, v, '0, INJECT_NONE);
		end
		for (int i = 0; i < 16; i++) begin
			issue_lookup(rand_vpn());
		end
		close_test("invalidated entries miss");
	endtask

	task automatic check_clean_write();
		logic [VPN_W-1:0] vpns [ENTRIES];
		logic [VPN_W-1:0] v;
		logic [VPN_W-1:0] flip;
		for (int i = 0; i < ENTRIES; i++) begin
			v = rand_vpn();
			v[INDEX_W-1:0] = i[INDEX_W-1:0];
			vpns[i] = v;
			issue_refill(REFILL_WRITE, v, rand_ppn(), INJECT_NONE);
		end
		for (int i = 0; i < ENTRIES; i++) begin
			issue_lookup(vpns[i]);
		end
		// Same index, different upper VPN bits.
		for (int i = 0; i < ENTRIES; i++) begin
			flip = '0;
			flip[INDEX_W + rand_below(VPN_W - INDEX_W)] = 1'b1;
			issue_lookup(vpns[i] ^ flip);
		end
		close_test("clean write then lookup");
	endtask

	task automatic check_single_inject();
		logic [VPN_W-1:0] v;
		for (int i = 0; i < 4; i++) begin
			v = rand_vpn();
			issue_refill(REFILL_WRITE, v, rand_ppn(), INJECT_SINGLE);
			issue_lookup(v);
		end
		close_test("single-bit injection");
	endtask

	task automatic check_double_inject();
		logic [VPN_W-1:0] v;
		for (int i = 0; i < 4; i++) begin
			v = rand_vpn();
			issue_refill(REFILL_WRITE, v, rand_ppn(), INJECT_DOUBLE);
			issue_lookup(v);
			issue_refill(REFILL_WRITE, v, rand_ppn(), INJECT_NONE);
			issue_lookup(v);
		end
		close_test("double-bit injection");
	endtask

	task automatic check_contention();
		logic             do_ref;
		logic             do_lk;
		stlb_refill_op_e  op;
		logic [1:0]       sel;
		logic [VPN_W-1:0] lv;
		for (int n = 0; n < N_RAND; n++) begin
			do_ref = (rand_below(2) == 0);
			op = (rand_below(4) == 0) ? REFILL_INVAL : REFILL_WRITE;
			sel = 2'(rand_below(3));
			do_lk = !pend && (rand_below(4) != 0);
			lv = (rand_below(2) == 0) ? ent_vpn[rand_below(ENTRIES)] : rand_vpn();
			drive_cycle(do_ref, op, rand_vpn(), rand_ppn(), stlb_inject_e'(sel), do_lk, lv);
		end
		close_test("contention and ordering");
	endtask

	task automatic check_inval_after_write();
		logic [VPN_W-1:0] v;
		for (int i = 0; i < 4; i++) begin
			v = rand_vpn();
			issue_refill(REFILL_WRITE, v, rand_ppn(), INJECT_NONE);
			issue_lookup(v);
			issue_refill(REFILL_INVAL, v, '0, INJECT_NONE);
			issue_lookup(v);
		end
		close_test("invalidate after write");
	endtask

	initial begin
		#(TOTAL_OPS * 10 * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d ns", TOTAL_OPS * 10 * CLK_PERIOD);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		seed          = 58870;
		n_pass        = 0;
		n_errors      = 0;
		n_req         = 0;
		n_resp        = 0;
		test_errors   = 0;
		pend          = 1'b0;
		pend_vpn      = '0;
		rst_n         = 1'b0;
		refill_valid  = 1'b0;
		refill_op     = REFILL_WRITE;
		refill_vpn    = '0;
		refill_ppn    = '0;
		refill_inject = INJECT_NONE;
		lookup_req    = 1'b0;
		lookup_vpn    = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			ent_valid[i]  = 1'b0;
			ent_vpn[i]    = '0;
			ent_ppn[i]    = '0;
			ent_inject[i] = INJECT_NONE;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		check_invalidated_miss();
		check_clean_write();
		check_single_inject();
		check_double_inject();
		check_contention();
		check_inval_after_write();
		if (n_resp != n_req) begin
			$display("Got %0d responses for %0d lookup requests", n_resp, n_req);
			n_errors++;
		end
		$display("Checks passed %0d, errors %0d", n_pass, n_errors);
		if (n_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== stlb_top.sv ====
// Tag side only; entries are undefined after reset, so every index must be invalidated before use.
`timescale 1ns/1ps

module stlb_top import stlb_pkg::*; #(
	parameter int INDEX_W = 3
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             refill_valid,
	input  stlb_refill_op_e  refill_op,
	input  logic [VPN_W-1:0] refill_vpn,
	input  logic [PPN_W-1:0] refill_ppn,
	input  stlb_inject_e     refill_inject,
	input  logic             lookup_req,
	input  logic [VPN_W-1:0] lookup_vpn,
	output logic             lookup_busy,
	output logic             resp_valid,
	output logic             resp_hit,
	output logic [PPN_W-1:0] resp_ppn,
	output stlb_ecc_e        resp_ecc
);

	logic                  wr_req;
	logic [INDEX_W-1:0]    wr_addr;
	logic [TAG_CODE_W-1:0] wr_code;
	logic                  rd_req;
	logic [INDEX_W-1:0]    rd_addr;
	logic                  rd_gnt;
	logic                  rd_data_valid;
	logic                  ram_cs;
	logic                  ram_we;
	logic [INDEX_W-1:0]    ram_addr;
	logic [TAG_CODE_W-1:0] ram_wdata;
	logic [TAG_CODE_W-1:0] ram_rdata;

	stlb_refill #(
		.INDEX_W (INDEX_W)
	) u_refill (
		.clk           (clk),
		.rst_n         (rst_n),
		.refill_valid  (refill_valid),
		.refill_op     (refill_op),
		.refill_vpn    (refill_vpn),
		.refill_ppn    (refill_ppn),
		.refill_inject (refill_inject),
		.wr_req        (wr_req),
		.wr_addr       (wr_addr),
		.wr_code       (wr_code)
	);

	stlb_lookup #(
		.INDEX_W (INDEX_W)
	) u_lookup (
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup_req    (lookup_req),
		.lookup_vpn    (lookup_vpn),
		.lookup_busy   (lookup_busy),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_gnt        (rd_gnt),
		.rd_data_valid (rd_data_valid),
		.ram_rdata     (ram_rdata),
		.resp_valid    (resp_valid),
		.resp_hit      (resp_hit),
		.resp_ppn      (resp_ppn),
		.resp_ecc      (resp_ecc)
	);

	stlb_ram_arbiter #(
		.INDEX_W (INDEX_W)
	) u_arbiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.wr_req        (wr_req),
		.wr_addr       (wr_addr),
		.wr_code       (wr_code),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_gnt        (rd_gnt),
		.rd_data_valid (rd_data_valid),
		.ram_cs        (ram_cs),
		.ram_we        (ram_we),
		.ram_addr      (ram_addr),
		.ram_wdata     (ram_wdata)
	);

	stlb_tag_ecc_ram #(
		.INDEX_W (INDEX_W)
	) u_tag_ram (
		.clk       (clk),
		.ram_cs    (ram_cs),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

endmodule

// ==== stlb_lookup.sv ====
// Source must not strobe lookup_req while lookup_busy is high; responses return in request order.
`timescale 1ns/1ps

module stlb_lookup import stlb_pkg::*; #(
	parameter int INDEX_W = 3
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  lookup_req,
	input  logic [VPN_W-1:0]      lookup_vpn,
	output logic                  lookup_busy,
	output logic                  rd_req,
	output logic [INDEX_W-1:0]    rd_addr,
	input  logic                  rd_gnt,
	input  logic                  rd_data_valid,
	input  logic [TAG_CODE_W-1:0] ram_rdata,
	output logic                  resp_valid,
	output logic                  resp_hit,
	output logic [PPN_W-1:0]      resp_ppn,
	output stlb_ecc_e             resp_ecc
);

	stlb_lookup_state_e    state_a;
	logic [VPN_W-1:0]      vpn_a;
	logic [VPN_W-1:0]      vpn_b;
	logic                  accept;
	logic [TAG_DATA_W-1:0] dec_data;
	stlb_ecc_e             dec_status;
	logic                  dec_hit;

	// ############################################################
	// Stage A holds the request until the arbiter grants the read
	// ############################################################

	assign lookup_busy = (state_a == LK_WAIT) & ~rd_gnt;
	assign accept      = lookup_req & ~lookup_busy;
	assign rd_req      = (state_a == LK_WAIT);
	assign rd_addr     = vpn_a[INDEX_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_a <= LK_EMPTY;
		end else begin
			if (accept) begin
				state_a <= LK_WAIT;
			end else if (rd_gnt) begin
				state_a <= LK_EMPTY;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			vpn_a <= lookup_vpn;
		end
	end

	// ############################################################
	// Stage B travels with the read, stage C checks the codeword
	// ############################################################

	always_ff @(posedge clk) begin
		if (rd_gnt) begin
			vpn_b <= vpn_a;
		end
	end

	always_comb begin
		ecc_decode(ram_rdata, dec_data, dec_status);
	end

	// An uncorrectable entry can't be trusted, so it always misses.
	assign dec_hit = dec_data[VALID_BIT] &&
		(dec_data[VPN_LSB +: VPN_W] == vpn_b) &&
		(dec_status != ECC_UNCORR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= rd_data_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_data_valid) begin
			resp_hit <= dec_hit;
			resp_ppn <= dec_data[PPN_W-1:0];
			resp_ecc <= dec_status;
		end
	end

endmodule

// ==== stlb_refill.sv ====
// Never stalls; the write reaches the RAM one cycle after refill_valid and overrides any read.
`timescale 1ns/1ps

module stlb_refill import stlb_pkg::*; #(
	parameter int INDEX_W = 3
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  refill_valid,
	input  stlb_refill_op_e       refill_op,
	input  logic [VPN_W-1:0]      refill_vpn,
	input  logic [PPN_W-1:0]      refill_ppn,
	input  stlb_inject_e          refill_inject,
	output logic                  wr_req,
	output logic [INDEX_W-1:0]    wr_addr,
	output logic [TAG_CODE_W-1:0] wr_code
);

	stlb_refill_op_e       r_op;
	stlb_inject_e          r_inject;
	logic [VPN_W-1:0]      r_vpn;
	logic [PPN_W-1:0]      r_ppn;
	logic [TAG_DATA_W-1:0] entry;
	logic [TAG_CODE_W-1:0] code;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_req <= 1'b0;
		end else begin
			wr_req <= refill_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (refill_valid) begin
			r_op     <= refill_op;
			r_inject <= refill_inject;
			r_vpn    <= refill_vpn;
			r_ppn    <= refill_ppn;
		end
	end

	// An invalidate stores an all-zero entry, which is also a valid codeword.
	assign entry = (r_op == REFILL_WRITE) ? {1'b1, r_vpn, r_ppn} : '0;
	assign code  = ecc_encode(entry);

	always_comb begin
		wr_code = code;
		case (r_inject)
			INJECT_SINGLE: wr_code[0] = ~code[0];
			INJECT_DOUBLE: wr_code[1:0] = ~code[1:0];
			default: wr_code = code;
		endcase
	end

	assign wr_addr = r_vpn[INDEX_W-1:0];

endmodule

// ==== stlb_ram_arbiter.sv ====
// Fixed priority, refill writes always win; a lookup read can be starved by continuous refills.
`timescale 1ns/1ps

module stlb_ram_arbiter import stlb_pkg::*; #(
	parameter int INDEX_W = 3
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wr_req,
	input  logic [INDEX_W-1:0]    wr_addr,
	input  logic [TAG_CODE_W-1:0] wr_code,
	input  logic                  rd_req,
	input  logic [INDEX_W-1:0]    rd_addr,
	output logic                  rd_gnt,
	output logic                  rd_data_valid,
	output logic                  ram_cs,
	output logic                  ram_we,
	output logic [INDEX_W-1:0]    ram_addr,
	output logic [TAG_CODE_W-1:0] ram_wdata
);

	logic rd_pending;

	// ############################################################
	// Port selection
	// ############################################################

	assign rd_gnt    = rd_req & ~wr_req;
	assign ram_cs    = wr_req | rd_req;
	assign ram_we    = wr_req;
	assign ram_addr  = wr_req ? wr_addr : rd_addr;
	assign ram_wdata = wr_code;

	// The RAM answers a granted read on the following cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= rd_gnt;
		end
	end

	assign rd_data_valid = rd_pending;

endmodule

// ==== stlb_tag_ecc_ram.sv ====
// Single port, read data valid one cycle after a read; array has no reset and powers up unknown.
`timescale 1ns/1ps

module stlb_tag_ecc_ram import stlb_pkg::*; #(
	parameter int INDEX_W = 3
) (
	input  logic                  clk,
	input  logic                  ram_cs,
	input  logic                  ram_we,
	input  logic [INDEX_W-1:0]    ram_addr,
	input  logic [TAG_CODE_W-1:0] ram_wdata,
	output logic [TAG_CODE_W-1:0] ram_rdata
);

	localparam int DEPTH = 2 ** INDEX_W;

	logic [TAG_CODE_W-1:0] mem [DEPTH];

	// Write and read share the port. Read data holds its value until the next read.
	always_ff @(posedge clk) begin
		if (ram_cs) begin
			if (ram_we) begin
				mem[ram_addr] <= ram_wdata;
			end else begin
				ram_rdata <= mem[ram_addr];
			end
		end
	end

endmodule

// ==== stlb_pkg.sv ====
// Codeword layout is fixed at 63 data bits plus 8 ECC bits; widths here must match every RAM.
package stlb_pkg;

	localparam int VPN_W      = 27;
	localparam int PPN_W      = 35;
	localparam int TAG_DATA_W = 1 + VPN_W + PPN_W;
	localparam int CHECK_W    = 7;
	localparam int TAG_CODE_W = TAG_DATA_W + CHECK_W + 1;

	// Entry data is {valid, vpn, ppn} from the top bit down.
	localparam int VALID_BIT = TAG_DATA_W - 1;
	localparam int VPN_LSB   = PPN_W;

	typedef enum logic {
		REFILL_WRITE = 1'b0,
		REFILL_INVAL = 1'b1
	} stlb_refill_op_e;

	typedef enum logic [1:0] {
		INJECT_NONE   = 2'd0,
		INJECT_SINGLE = 2'd1,
		INJECT_DOUBLE = 2'd2
	} stlb_inject_e;

	typedef enum logic [1:0] {
		ECC_CLEAN     = 2'd0,
		ECC_CORRECTED = 2'd1,
		ECC_UNCORR    = 2'd2
	} stlb_ecc_e;

	typedef enum logic {
		LK_EMPTY = 1'b0,
		LK_WAIT  = 1'b1
	} stlb_lookup_state_e;

	// ############################################################
	// SECDED over a Hamming code. Codeword bit p is Hamming position p for
	// p = 1..70, power-of-two positions carry check bits, bit 0 is overall parity.
	// ############################################################

	function automatic logic [TAG_CODE_W-1:0] ecc_encode(input logic [TAG_DATA_W-1:0] data);
		logic [TAG_CODE_W-1:0] code;
		logic                  chk;
		int                    d;
		code = '0;
		d = 0;
		for (int p = 1; p < TAG_CODE_W; p++) begin
			if ((p & (p - 1)) != 0) begin
				code[p] = data[d];
				d++;
			end
		end
		for (int c = 0; c < CHECK_W; c++) begin
			chk = 1'b0;
			for (int p = 1; p < TAG_CODE_W; p++) begin
				if (((p >> c) & 1) != 0) begin
					chk = chk ^ code[p];
				end
			end
			code[1 << c] = chk;
		end
		code[0] = ^code[TAG_CODE_W-1:1];
		return code;
	endfunction

	function automatic void ecc_decode(
		input  logic [TAG_CODE_W-1:0] code,
		output logic [TAG_DATA_W-1:0] data,
		output stlb_ecc_e             status
	);
		logic [TAG_CODE_W-1:0] fixed;
		logic [CHECK_W-1:0]    syndrome;
		logic                  parity_err;
		int                    d;
		fixed = code;
		syndrome = '0;
		for (int c = 0; c < CHECK_W; c++) begin
			for (int p = 1; p < TAG_CODE_W; p++) begin
				if (((p >> c) & 1) != 0) begin
					syndrome[c] = syndrome[c] ^ code[p];
				end
			end
		end
		parity_err = ^code;
		if (parity_err) begin
			// A zero syndrome here means the parity bit itself flipped.
			status = ECC_CORRECTED;
			if (syndrome < TAG_CODE_W) begin
				fixed[syndrome] = ~fixed[syndrome];
			end
		end else if (syndrome != '0) begin
			status = ECC_UNCORR;
		end else begin
			status = ECC_CLEAN;
		end
		data = '0;
		d = 0;
		for (int p = 1; p < TAG_CODE_W; p++) begin
			if ((p & (p - 1)) != 0) begin
				data[d] = fixed[p];
				d++;
			end
		end
	endfunction

endpackage
